// ==== design/cache_ctrl.sv ====
`include "enokida_params.svh"

module cache_ctrl
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                capture_en_i,
    input  logic                proc_req_i,
    input  cache_pkg::addr_t    proc_addr_i,
    input  logic                proc_we_i,
    input  cache_pkg::be_t      proc_be_i,
    input  cache_pkg::word_t    proc_wdata_i,
    output logic                proc_gnt_o,
    output logic                proc_rvalid_o,
    output cache_pkg::word_t    proc_rdata_o,
    output logic                mem_req_o,
    output cache_pkg::addr_t    mem_addr_o,
    output logic                mem_we_o,
    output cache_pkg::be_t      mem_be_o,
    output cache_pkg::word_t    mem_wdata_o,
    input  logic                mem_gnt_i,
    input  logic                mem_rvalid_i,
    input  cache_pkg::word_t    mem_rdata_i,
    output cache_pkg::index_t   st_rd_index_o,
    output logic                st_wr_en_o,
    output cache_pkg::index_t   st_wr_index_o,
    output cache_pkg::tag_t     st_wr_tag_o,
    output cache_pkg::word_t    st_wr_data_o,
    output cache_pkg::be_t      st_wr_be_o,
    output logic                st_wr_dirty_o,
    input  cache_pkg::tag_t     st_rd_tag_i,
    input  logic                st_rd_valid_i,
    input  logic                st_rd_dirty_i,
    input  cache_pkg::word_t    st_rd_data_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_COMPARE,
        S_WB_REQ,
        S_WB_WAIT,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_COMPLETE
    } state_t;

    state_t             state_q;
    cache_pkg::addr_t   req_addr_q;
    logic               req_we_q;
    cache_pkg::be_t     req_be_q;
    cache_pkg::word_t   req_wdata_q;
    cache_pkg::index_t  req_index;
    cache_pkg::tag_t    req_tag;
    logic               hit;
    logic               fill_write;

    assign req_index  = req_addr_q[`ENK_INDEX_MSB:`ENK_INDEX_LSB];
    assign req_tag    = req_addr_q[`ENK_ADDR_W-1:`ENK_TAG_LSB];
    assign hit        = st_rd_valid_i && (st_rd_tag_i == req_tag);
    assign fill_write = (state_q == S_FILL_WAIT) && mem_rvalid_i;

    // The line of the pending access is read every cycle, so the victim stays on rd_*
    assign st_rd_index_o = req_index;
    assign st_wr_en_o    = fill_write || ((state_q == S_COMPARE) && hit && req_we_q);
    assign st_wr_index_o = req_index;
    assign st_wr_tag_o   = req_tag;
    assign st_wr_data_o  = fill_write ? mem_rdata_i : req_wdata_q;
    assign st_wr_be_o    = fill_write ? '1 : req_be_q;
    assign st_wr_dirty_o = !fill_write;

    // Memory request follows the state and is held there until the grant
    assign mem_req_o   = (state_q == S_WB_REQ) || (state_q == S_FILL_REQ);
    assign mem_we_o    = (state_q == S_WB_REQ);
    assign mem_be_o    = '1;
    assign mem_wdata_o = st_rd_data_i;
    assign mem_addr_o  = (state_q == S_WB_REQ)
                       ? {st_rd_tag_i, req_index, {`ENK_INDEX_LSB{1'b0}}}
                       : {req_addr_q[`ENK_ADDR_W-1:`ENK_INDEX_LSB], {`ENK_INDEX_LSB{1'b0}}};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q       <= S_IDLE;
            proc_gnt_o    <= 1'b0;
            proc_rvalid_o <= 1'b0;
        end
        else
        begin
            case (state_q)
                S_IDLE:
                begin
                    proc_rvalid_o <= 1'b0;
                    if (proc_req_i && !capture_en_i)
                        state_q <= S_LOOKUP;
                end
                S_LOOKUP:
                    state_q <= S_COMPARE;
                S_COMPARE:
                begin
                    if (hit)
                    begin
                        proc_gnt_o <= 1'b1;
                        state_q    <= S_COMPLETE;
                    end
                    else if (st_rd_valid_i && st_rd_dirty_i)
                        state_q <= S_WB_REQ;
                    else
                        state_q <= S_FILL_REQ;
                end
                S_WB_REQ:
                    if (mem_gnt_i)
                        state_q <= S_WB_WAIT;
                S_WB_WAIT:
                    if (mem_rvalid_i)
                        state_q <= S_FILL_REQ;
                S_FILL_REQ:
                    if (mem_gnt_i)
                        state_q <= S_FILL_WAIT;
                // After the fill the access runs through lookup again and hits
                S_FILL_WAIT:
                    if (mem_rvalid_i)
                        state_q <= S_LOOKUP;
                S_COMPLETE:
                begin
                    proc_gnt_o    <= 1'b0;
                    proc_rvalid_o <= 1'b1;
                    state_q       <= S_IDLE;
                end
                default:
                    state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            req_addr_q <= '0;
        else if ((state_q == S_IDLE) && proc_req_i)
            req_addr_q <= proc_addr_i;
    end

    always_ff @(posedge clk)
    begin
        if ((state_q == S_IDLE) && proc_req_i)
        begin
            req_we_q    <= proc_we_i;
            req_be_q    <= proc_be_i;
            req_wdata_q <= proc_wdata_i;
        end
        if ((state_q == S_COMPARE) && hit)
            proc_rdata_o <= req_we_q ? '0 : st_rd_data_i;
    end

    gnt_rvalid_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_gnt_i && mem_rvalid_i));

    mem_req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o)));

endmodule

// ==== design/cache_pkg.sv ====
`include "enokida_params.svh"

package cache_pkg;

    // Byte address as seen on both ports
    typedef logic [`ENK_ADDR_W-1:0] addr_t;

    typedef logic [`ENK_DATA_W-1:0] word_t;

    typedef logic [`ENK_BE_W-1:0] be_t;

    // Line index and tag slices of addr_t
    typedef logic [`ENK_INDEX_MSB-`ENK_INDEX_LSB:0] index_t;

    typedef logic [`ENK_ADDR_W-`ENK_TAG_LSB-1:0] tag_t;

    // Current owner of the shared memory port
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_CACHE,
        REQ_BYPASS
    } requester_t;

endpackage

// ==== design/cache_store.sv ====
`include "enokida_params.svh"

module cache_store
(
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::index_t   rd_index_i,
    input  logic                wr_en_i,
    input  cache_pkg::index_t   wr_index_i,
    input  cache_pkg::tag_t     wr_tag_i,
    input  cache_pkg::word_t    wr_data_i,
    input  cache_pkg::be_t      wr_be_i,
    input  logic                wr_dirty_i,
    output cache_pkg::tag_t     rd_tag_o,
    output logic                rd_valid_o,
    output logic                rd_dirty_o,
    output cache_pkg::word_t    rd_data_o
);

    logic [`ENK_LINES-1:0] valid_q;
    logic [`ENK_LINES-1:0] dirty_q;
    cache_pkg::tag_t       tag_q  [`ENK_LINES];
    cache_pkg::word_t      data_q [`ENK_LINES];

    // Line state bits, all lines invalid and clean out of reset
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_q    <= '0;
            dirty_q    <= '0;
            rd_valid_o <= 1'b0;
            rd_dirty_o <= 1'b0;
        end
        else
        begin
            rd_valid_o <= valid_q[rd_index_i];
            rd_dirty_o <= dirty_q[rd_index_i];
            if (wr_en_i)
            begin
                valid_q[wr_index_i] <= 1'b1;
                dirty_q[wr_index_i] <= wr_dirty_i;
            end
        end
    end

    // Tag and data arrays; a read in the same cycle as a write returns the old word
    always_ff @(posedge clk)
    begin
        rd_tag_o  <= tag_q[rd_index_i];
        rd_data_o <= data_q[rd_index_i];
        if (wr_en_i)
        begin
            tag_q[wr_index_i] <= wr_tag_i;
            for (int b = 0; b < `ENK_BE_W; b++)
            begin
                if (wr_be_i[b])
                    data_q[wr_index_i][8*b +: 8] <= wr_data_i[8*b +: 8];
            end
        end
    end

    rd_index_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_index_i));

endmodule

// ==== design/capture_bypass.sv ====
module capture_bypass
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                capture_en_i,
    input  logic                proc_req_i,
    input  cache_pkg::addr_t    proc_addr_i,
    input  logic                proc_we_i,
    input  cache_pkg::be_t      proc_be_i,
    input  cache_pkg::word_t    proc_wdata_i,
    output logic                proc_gnt_o,
    output logic                proc_rvalid_o,
    output cache_pkg::word_t    proc_rdata_o,
    output logic                mem_req_o,
    output cache_pkg::addr_t    mem_addr_o,
    output logic                mem_we_o,
    output cache_pkg::be_t      mem_be_o,
    output cache_pkg::word_t    mem_wdata_o,
    input  logic                mem_gnt_i,
    input  logic                mem_rvalid_i,
    input  cache_pkg::word_t    mem_rdata_i
);

    typedef enum logic [1:0] {
        B_IDLE,
        B_WAIT_GNT,
        B_WAIT_RVALID
    } state_t;

    state_t state_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q       <= B_IDLE;
            mem_req_o     <= 1'b0;
            proc_gnt_o    <= 1'b0;
            proc_rvalid_o <= 1'b0;
        end
        else
        begin
            case (state_q)
                B_IDLE:
                begin
                    proc_rvalid_o <= 1'b0;
                    if (proc_req_i && capture_en_i)
                    begin
                        mem_req_o <= 1'b1;
                        state_q   <= B_WAIT_GNT;
                    end
                end
                B_WAIT_GNT:
                begin
                    if (mem_gnt_i)
                    begin
                        mem_req_o  <= 1'b0;
                        proc_gnt_o <= 1'b1;
                        state_q    <= B_WAIT_RVALID;
                    end
                end
                B_WAIT_RVALID:
                begin
                    proc_gnt_o <= 1'b0;
                    if (mem_rvalid_i)
                    begin
                        proc_rvalid_o <= 1'b1;
                        state_q       <= B_IDLE;
                    end
                end
                default:
                    state_q <= B_IDLE;
            endcase
        end
    end

    // Stores complete with zero read data
    always_ff @(posedge clk)
    begin
        if ((state_q == B_IDLE) && proc_req_i)
        begin
            mem_addr_o  <= proc_addr_i;
            mem_we_o    <= proc_we_i;
            mem_be_o    <= proc_be_i;
            mem_wdata_o <= proc_wdata_i;
        end
        if ((state_q == B_WAIT_RVALID) && mem_rvalid_i)
            proc_rdata_o <= mem_we_o ? '0 : mem_rdata_i;
    end

endmodule

// ==== design/enokida_params.svh ====
`ifndef ENOKIDA_PARAMS_SVH
`define ENOKIDA_PARAMS_SVH

// Bus widths shared by the processor and memory ports
`define ENK_ADDR_W      16
`define ENK_DATA_W      32
`define ENK_BE_W        4

// Direct-mapped geometry with one word per line
`define ENK_LINES       16

// Address split into byte offset, line index and tag
`define ENK_INDEX_LSB   2
`define ENK_INDEX_MSB   5
`define ENK_TAG_LSB     6

`endif

// ==== design/enokida_top.sv ====
module enokida_top
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                capture_en_i,
    input  logic                proc_req_i,
    input  cache_pkg::addr_t    proc_addr_i,
    input  logic                proc_we_i,
    input  cache_pkg::be_t      proc_be_i,
    input  cache_pkg::word_t    proc_wdata_i,
    output logic                proc_gnt_o,
    output logic                proc_rvalid_o,
    output cache_pkg::word_t    proc_rdata_o,
    output logic                mem_req_o,
    output cache_pkg::addr_t    mem_addr_o,
    output logic                mem_we_o,
    output cache_pkg::be_t      mem_be_o,
    output cache_pkg::word_t    mem_wdata_o,
    input  logic                mem_gnt_i,
    input  logic                mem_rvalid_i,
    input  cache_pkg::word_t    mem_rdata_i
);

    logic               c_gnt, c_rvalid;
    cache_pkg::word_t   c_rdata;
    logic               b_gnt, b_rvalid;
    cache_pkg::word_t   b_rdata;

    logic               cm_req, cm_we, cm_gnt, cm_rvalid;
    cache_pkg::addr_t   cm_addr;
    cache_pkg::be_t     cm_be;
    cache_pkg::word_t   cm_wdata, cm_rdata;
    logic               bm_req, bm_we, bm_gnt, bm_rvalid;
    cache_pkg::addr_t   bm_addr;
    cache_pkg::be_t     bm_be;
    cache_pkg::word_t   bm_wdata, bm_rdata;

    cache_pkg::index_t  st_rd_index, st_wr_index;
    logic               st_wr_en, st_wr_dirty, st_rd_valid, st_rd_dirty;
    cache_pkg::tag_t    st_wr_tag, st_rd_tag;
    cache_pkg::word_t   st_wr_data, st_rd_data;
    cache_pkg::be_t     st_wr_be;

    cache_store store_i (
        .clk, .rst_n,
        .rd_index_i(st_rd_index), .wr_en_i(st_wr_en), .wr_index_i(st_wr_index),
        .wr_tag_i(st_wr_tag), .wr_data_i(st_wr_data), .wr_be_i(st_wr_be),
        .wr_dirty_i(st_wr_dirty), .rd_tag_o(st_rd_tag), .rd_valid_o(st_rd_valid),
        .rd_dirty_o(st_rd_dirty), .rd_data_o(st_rd_data)
    );

    cache_ctrl ctrl_i (
        .clk, .rst_n, .capture_en_i, .proc_req_i, .proc_addr_i, .proc_we_i,
        .proc_be_i, .proc_wdata_i,
        .proc_gnt_o(c_gnt), .proc_rvalid_o(c_rvalid), .proc_rdata_o(c_rdata),
        .mem_req_o(cm_req), .mem_addr_o(cm_addr), .mem_we_o(cm_we), .mem_be_o(cm_be),
        .mem_wdata_o(cm_wdata), .mem_gnt_i(cm_gnt), .mem_rvalid_i(cm_rvalid),
        .mem_rdata_i(cm_rdata),
        .st_rd_index_o(st_rd_index), .st_wr_en_o(st_wr_en), .st_wr_index_o(st_wr_index),
        .st_wr_tag_o(st_wr_tag), .st_wr_data_o(st_wr_data), .st_wr_be_o(st_wr_be),
        .st_wr_dirty_o(st_wr_dirty), .st_rd_tag_i(st_rd_tag), .st_rd_valid_i(st_rd_valid),
        .st_rd_dirty_i(st_rd_dirty), .st_rd_data_i(st_rd_data)
    );

    capture_bypass bypass_i (
        .clk, .rst_n, .capture_en_i, .proc_req_i, .proc_addr_i, .proc_we_i,
        .proc_be_i, .proc_wdata_i,
        .proc_gnt_o(b_gnt), .proc_rvalid_o(b_rvalid), .proc_rdata_o(b_rdata),
        .mem_req_o(bm_req), .mem_addr_o(bm_addr), .mem_we_o(bm_we), .mem_be_o(bm_be),
        .mem_wdata_o(bm_wdata), .mem_gnt_i(bm_gnt), .mem_rvalid_i(bm_rvalid),
        .mem_rdata_i(bm_rdata)
    );

    mem_arbiter arb_i (
        .clk, .rst_n,
        .cache_req_i(cm_req), .cache_addr_i(cm_addr), .cache_we_i(cm_we),
        .cache_be_i(cm_be), .cache_wdata_i(cm_wdata), .cache_gnt_o(cm_gnt),
        .cache_rvalid_o(cm_rvalid), .cache_rdata_o(cm_rdata),
        .byp_req_i(bm_req), .byp_addr_i(bm_addr), .byp_we_i(bm_we),
        .byp_be_i(bm_be), .byp_wdata_i(bm_wdata), .byp_gnt_o(bm_gnt),
        .byp_rvalid_o(bm_rvalid), .byp_rdata_o(bm_rdata),
        .mem_req_o, .mem_addr_o, .mem_we_o, .mem_be_o, .mem_wdata_o,
        .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i
    );

    // Only one peer is active at a time, so the responses never collide
    assign proc_gnt_o    = c_gnt | b_gnt;
    assign proc_rvalid_o = c_rvalid | b_rvalid;
    assign proc_rdata_o  = c_rvalid ? c_rdata : b_rdata;

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cache_req_i,
    input  cache_pkg::addr_t    cache_addr_i,
    input  logic                cache_we_i,
    input  cache_pkg::be_t      cache_be_i,
    input  cache_pkg::word_t    cache_wdata_i,
    output logic                cache_gnt_o,
    output logic                cache_rvalid_o,
    output cache_pkg::word_t    cache_rdata_o,
    input  logic                byp_req_i,
    input  cache_pkg::addr_t    byp_addr_i,
    input  logic                byp_we_i,
    input  cache_pkg::be_t      byp_be_i,
    input  cache_pkg::word_t    byp_wdata_i,
    output logic                byp_gnt_o,
    output logic                byp_rvalid_o,
    output cache_pkg::word_t    byp_rdata_o,
    output logic                mem_req_o,
    output cache_pkg::addr_t    mem_addr_o,
    output logic                mem_we_o,
    output cache_pkg::be_t      mem_be_o,
    output cache_pkg::word_t    mem_wdata_o,
    input  logic                mem_gnt_i,
    input  logic                mem_rvalid_i,
    input  cache_pkg::word_t    mem_rdata_i
);

    cache_pkg::requester_t owner_q;
    logic                  own_cache;

    // Ownership lasts from the request until the access's rvalid
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            owner_q <= cache_pkg::REQ_NONE;
        else if (owner_q == cache_pkg::REQ_NONE)
        begin
            if (cache_req_i)
                owner_q <= cache_pkg::REQ_CACHE;
            else if (byp_req_i)
                owner_q <= cache_pkg::REQ_BYPASS;
        end
        else if (mem_rvalid_i)
            owner_q <= cache_pkg::REQ_NONE;
    end

    assign own_cache = (owner_q == cache_pkg::REQ_CACHE);

    assign mem_req_o   = own_cache ? cache_req_i
                       : ((owner_q == cache_pkg::REQ_BYPASS) && byp_req_i);
    assign mem_addr_o  = own_cache ? cache_addr_i  : byp_addr_i;
    assign mem_we_o    = own_cache ? cache_we_i    : byp_we_i;
    assign mem_be_o    = own_cache ? cache_be_i    : byp_be_i;
    assign mem_wdata_o = own_cache ? cache_wdata_i : byp_wdata_i;

    assign cache_gnt_o    = mem_gnt_i && own_cache;
    assign cache_rvalid_o = mem_rvalid_i && own_cache;
    assign cache_rdata_o  = mem_rdata_i;
    assign byp_gnt_o      = mem_gnt_i && (owner_q == cache_pkg::REQ_BYPASS);
    assign byp_rvalid_o   = mem_rvalid_i && (owner_q == cache_pkg::REQ_BYPASS);
    assign byp_rdata_o    = mem_rdata_i;

    no_orphan_resp_a: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_gnt_i || mem_rvalid_i) |-> (owner_q != cache_pkg::REQ_NONE));

endmodule

// ==== files.f ====
+incdir+design
design/cache_pkg.sv
design/cache_store.sv
design/cache_ctrl.sv
design/capture_bypass.sv
design/mem_arbiter.sv
design/enokida_top.sv
tests/tb_mem_model.sv
tests/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_top -f files.f -o Vtb_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

exit 0

// ==== tests/tb_mem_model.sv ====
module tb_mem_model
#(
    parameter logic [31:0] SEED    = 32'h1,
    parameter logic [31:0] PATTERN = 32'h0
)
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req_i,
    input  logic [15:0] mem_addr_i,
    input  logic        mem_we_i,
    input  logic [3:0]  mem_be_i,
    input  logic [31:0] mem_wdata_i,
    output logic        mem_gnt_o,
    output logic        mem_rvalid_o,
    output logic [31:0] mem_rdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [16384];
    logic [31:0] lcg_state;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Delay of 0 to 3 cycles taken from the upper LCG bits
    function automatic int pick_delay();
        lcg_state = lcg_step(lcg_state);
        return int'(lcg_state[25:24]);
    endfunction

    initial
    begin
        logic [15:0] a;
        for (int i = 0; i < 16384; i++)
        begin
            a = {i[13:0], 2'b00};
            mem[i] = {~a, a} ^ PATTERN;
        end
    end

    initial
    begin
        logic [15:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
        int          delay;
        lcg_state    = SEED;
        mem_gnt_o    = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
        forever
        begin
            @(posedge clk);
            if (rst_n && mem_req_i)
            begin
                delay = pick_delay();
                repeat (delay) @(posedge clk);
                // The request is held until gnt, so its fields are still valid here
                addr  = mem_addr_i;
                we    = mem_we_i;
                be    = mem_be_i;
                wdata = mem_wdata_i;
                mem_gnt_o <= 1'b1;
                @(posedge clk);
                mem_gnt_o <= 1'b0;
                delay = pick_delay();
                repeat (delay) @(posedge clk);
                if (we)
                begin
                    for (int b = 0; b < 4; b++)
                    begin
                        if (be[b])
                            mem[addr[15:2]][8*b +: 8] = wdata[8*b +: 8];
                    end
                    mem_rdata_o <= '0;
                end
                else
                    mem_rdata_o <= mem[addr[15:2]];
                mem_rvalid_o <= 1'b1;
                @(posedge clk);
                mem_rvalid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_top.sv ====
module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED        = 32'h4872a7da;
    localparam logic [31:0] PATTERN     = 32'h3c5a_96e1;
    localparam int          RESET_CYC   = 10;
    localparam int          IDLE_CYC    = 8;
    localparam int          RAND_OPS    = 24;
    localparam int          TOTAL_ACC   = 4 + 2 + 3 + RAND_OPS + 6;
    localparam int          CYCLE_LIMIT = TOTAL_ACC * 20 + RESET_CYC;

    logic        clk;
    logic        rst_n;
    logic        capture_en;
    logic        proc_req;
    logic [15:0] proc_addr;
    logic        proc_we;
    logic [3:0]  proc_be;
    logic [31:0] proc_wdata;
    logic        proc_gnt;
    logic        proc_rvalid;
    logic [31:0] proc_rdata;
    logic        mem_req, mem_we, mem_gnt, mem_rvalid;
    logic [15:0] mem_addr;
    logic [3:0]  mem_be;
    logic [31:0] mem_wdata, mem_rdata;

    logic [31:0] shadow [16384];
    logic [31:0] expect_q [$];
    logic [31:0] rand_state;
    int          errors;
    int          checks;
    int          cycle_cnt;
    int          mem_writes;

    enokida_top dut_i (
        .clk(clk), .rst_n(rst_n), .capture_en_i(capture_en),
        .proc_req_i(proc_req), .proc_addr_i(proc_addr), .proc_we_i(proc_we),
        .proc_be_i(proc_be), .proc_wdata_i(proc_wdata),
        .proc_gnt_o(proc_gnt), .proc_rvalid_o(proc_rvalid), .proc_rdata_o(proc_rdata),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_we_o(mem_we),
        .mem_be_o(mem_be), .mem_wdata_o(mem_wdata),
        .mem_gnt_i(mem_gnt), .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
    );

    tb_mem_model #(.SEED(SEED), .PATTERN(PATTERN)) mem_i (
        .clk(clk), .rst_n(rst_n), .mem_req_i(mem_req), .mem_addr_i(mem_addr),
        .mem_we_i(mem_we), .mem_be_i(mem_be), .mem_wdata_i(mem_wdata),
        .mem_gnt_o(mem_gnt), .mem_rvalid_o(mem_rvalid), .mem_rdata_o(mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected load word straight from the shadow memory
    function automatic logic [31:0] expected_load(input logic [15:0] addr);
        return shadow[addr[15:2]];
    endfunction

    function automatic void apply_store(input logic [15:0] addr, input logic [3:0] be,
                                        input logic [31:0] wdata);
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                shadow[addr[15:2]][8*b +: 8] = wdata[8*b +: 8];
        end
    endfunction

    // Each rvalid is matched against the oldest outstanding expectation
    always @(posedge clk)
    begin
        if (rst_n && proc_rvalid)
        begin
            checks++;
            if (expect_q.size() == 0)
            begin
                $display("rvalid at %0t without an outstanding access", $time);
                errors++;
            end
            else if (proc_rdata !== expect_q[0])
            begin
                $display("ERR t=%0t proc_rdata_o expected %h got %h",
                         $time, expect_q[0], proc_rdata);
                errors++;
                void'(expect_q.pop_front());
            end
            else
                void'(expect_q.pop_front());
        end
    end

    always @(posedge clk)
    begin
        if (rst_n && mem_req && mem_we && mem_gnt)
            mem_writes++;
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, an access never completed", cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic access(input logic we, input logic [15:0] addr, input logic [3:0] be,
                          input logic [31:0] wdata, output int gnt_lat,
                          output int rvalid_lat, output logic mem_seen);
        int n;
        n = 0;
        mem_seen = 1'b0;
        if (we)
        begin
            apply_store(addr, be, wdata);
            expect_q.push_back(32'h0);
        end
        else
            expect_q.push_back(expected_load(addr));
        @(posedge clk);
        proc_req   <= 1'b1;
        proc_addr  <= addr;
        proc_we    <= we;
        proc_be    <= be;
        proc_wdata <= wdata;
        do
        begin
            @(posedge clk);
            n++;
            if (mem_req)
                mem_seen = 1'b1;
        end
        while (!proc_gnt);
        proc_req <= 1'b0;
        gnt_lat = n - 2;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (mem_req)
                mem_seen = 1'b1;
        end
        while (!proc_rvalid);
        rvalid_lat = n;
    endtask

    task automatic quick_access(input logic we, input logic [15:0] addr,
                                input logic [3:0] be, input logic [31:0] wdata);
        int g;
        int r;
        logic m;
        access(we, addr, be, wdata, g, r, m);
    endtask

    task automatic finish_test(input int num, input string name, input int err_before);
        // One more edge lets the comparison of the last rvalid land first
        @(posedge clk);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "failed");
    endtask

    initial
    begin
        int          e0;
        int          g;
        int          r;
        int          w0;
        int          stores;
        logic        m;
        logic [31:0] v;
        logic [15:0] a;
        logic [15:0] ta;
        errors     = 0;
        checks     = 0;
        cycle_cnt  = 0;
        mem_writes = 0;
        rand_state = SEED;
        rst_n      = 1'b0;
        capture_en = 1'b0;
        proc_req   = 1'b0;
        proc_addr  = '0;
        proc_we    = 1'b0;
        proc_be    = '0;
        proc_wdata = '0;
        for (int i = 0; i < 16384; i++)
        begin
            a = {i[13:0], 2'b00};
            shadow[i] = {~a, a} ^ PATTERN;
        end
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;

        e0 = errors;
        repeat (IDLE_CYC) @(posedge clk)
        begin
            checks++;
            if (proc_gnt !== 1'b0)
            begin
                $display("ERR t=%0t proc_gnt_o expected 0 got %b", $time, proc_gnt);
                errors++;
            end
            if (proc_rvalid !== 1'b0)
            begin
                $display("ERR t=%0t proc_rvalid_o expected 0 got %b", $time, proc_rvalid);
                errors++;
            end
            if (mem_req !== 1'b0)
            begin
                $display("ERR t=%0t mem_req_o expected 0 got %b", $time, mem_req);
                errors++;
            end
        end
        finish_test(1, "reset idle", e0);

        e0 = errors;
        quick_access(1'b0, 16'h0040, 4'hf, 32'h0);
        quick_access(1'b0, 16'h0104, 4'hf, 32'h0);
        quick_access(1'b0, 16'h0208, 4'hf, 32'h0);
        quick_access(1'b0, 16'h030c, 4'hf, 32'h0);
        finish_test(2, "fresh loads", e0);

        e0 = errors;
        quick_access(1'b1, 16'h0104, 4'b0110, 32'hdead_beef);
        access(1'b0, 16'h0104, 4'hf, 32'h0, g, r, m);
        checks++;
        if (g != 2)
        begin
            $display("ERR t=%0t proc_gnt_o latency expected 2 got %0d", $time, g);
            errors++;
        end
        if (r != 1)
        begin
            $display("ERR t=%0t proc_rvalid_o latency expected 1 got %0d", $time, r);
            errors++;
        end
        if (m)
        begin
            $display("ERR t=%0t mem_req_o expected 0 got 1", $time);
            errors++;
        end
        finish_test(3, "partial store and hit", e0);

        e0 = errors;
        quick_access(1'b1, 16'h0410, 4'hf, 32'h1234_5678);
        quick_access(1'b0, 16'h0810, 4'hf, 32'h0);
        quick_access(1'b0, 16'h0410, 4'hf, 32'h0);
        for (int i = 0; i < RAND_OPS; i++)
        begin
            rand_state = lcg_step(rand_state);
            v = rand_state;
            ta = 16'h1000 | {8'b0, v[25:24], 6'b0} | {10'b0, v[21:18], 2'b00};
            rand_state = lcg_step(rand_state);
            quick_access(v[30], ta, (v[29:26] == 4'h0) ? 4'hf : v[29:26], rand_state);
        end
        finish_test(4, "write-back and random", e0);

        e0 = errors;
        @(posedge clk);
        capture_en <= 1'b1;
        w0 = mem_writes;
        stores = 0;
        quick_access(1'b0, 16'h8000, 4'hf, 32'h0);
        quick_access(1'b1, 16'h8004, 4'b1001, 32'hcafe_f00d);
        stores++;
        quick_access(1'b0, 16'h8004, 4'hf, 32'h0);
        quick_access(1'b1, 16'h8100, 4'hf, 32'h0bad_cafe);
        stores++;
        quick_access(1'b0, 16'h8100, 4'hf, 32'h0);
        quick_access(1'b0, 16'h8208, 4'hf, 32'h0);
        @(posedge clk);
        checks++;
        if (mem_writes - w0 != stores)
        begin
            $display("ERR t=%0t mem_we_o writes expected %0d got %0d",
                     $time, stores, mem_writes - w0);
            errors++;
        end
        finish_test(5, "capture mode", e0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
